// File: design/csr_index_gen_params.svh
// Width, depth and threshold macros for the CSR index generator
// Shared by the type package and every RTL module

`ifndef CSR_INDEX_GEN_PARAMS_SVH
`define CSR_INDEX_GEN_PARAMS_SVH

// ----------------------------
// Datapath widths
// ----------------------------

// Index and stride counter width
`define CSR_INDEX_W 16

// Array base pointer and formed offset
`define CSR_ADDR_W 32

// Offset shift amount, covers 0 to 31
`define CSR_SHIFT_W 5

// ----------------------------
// Request FIFO sizing
// ----------------------------

// Kept a power of two so the pointers wrap on their own
`define CSR_FIFO_DEPTH 32

// Half the depth leaves room for pushes already in flight when the FSM pauses
`define CSR_FIFO_PROG_THRESH 16

`endif

// File: design/csr_index_types_pkg.sv
// Vector types for indices, addresses, shift amounts and FIFO occupancy
// Also the width of one packed request word

`default_nettype none

`include "csr_index_gen_params.svh"

package csr_index_types_pkg;

    // ----------------------------
    // Datapath vectors
    // ----------------------------

    // Vertex or edge index, also the counter value
    typedef logic [`CSR_INDEX_W-1:0] index_t;

    // Base pointer or byte offset
    typedef logic [`CSR_ADDR_W-1:0] addr_t;

    // Offset shift amount
    typedef logic [`CSR_SHIFT_W-1:0] shift_t;

    // ----------------------------
    // FIFO bookkeeping
    // ----------------------------

    // One extra bit so a full FIFO can be told apart from an empty one
    typedef logic [$clog2(`CSR_FIFO_DEPTH):0] fifo_level_t;

    // Request word holds base, offset and index in that order
    localparam int request_w = 2 * $bits(addr_t) + $bits(index_t);

endpackage

`default_nettype wire

// File: design/csr_index_ctrl_pkg.sv
// Control types for the CSR index generator
// Generator FSM state encoding

`default_nettype none

package csr_index_ctrl_pkg;

    // ----------------------------
    // Generator states
    // ----------------------------

    typedef enum logic [2:0] {
        GEN_RESET  = 3'd0,
        GEN_IDLE   = 3'd1,
        GEN_LOAD   = 3'd2,
        GEN_START  = 3'd3,
        GEN_BUSY   = 3'd4,
        // Back-pressure from the request FIFO
        GEN_PAUSE  = 3'd5,
        GEN_RESUME = 3'd6,
        GEN_DONE   = 3'd7
    } gen_state_t;

endpackage

`default_nettype wire

// File: design/index_counter.sv
// Loadable stride counter
// Holds the current index of a generation

`timescale 1ns/1ps
`default_nettype none

`include "csr_index_gen_params.svh"

module index_counter (
    input  wire logic                          ap_clk,
    input  wire logic                          areset_generator,
    input  wire logic                          load,
    input  wire logic                          enable,
    input  wire csr_index_types_pkg::index_t   load_value,
    input  wire csr_index_types_pkg::index_t   stride,
    output csr_index_types_pkg::index_t        count
);

    // ----------------------------
    // Count register
    // ----------------------------

    // Load wins over a step, though the FSM never asks for both
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            count <= '0;
        end else if (load) begin
            count <= load_value;
        end else if (enable) begin
            count <= count + stride;
        end
    end

    // ----------------------------
    // Checks
    // ----------------------------

    // Load happens only in LOAD and steps only in BUSY
    a_load_enable_exclusive : assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        !(load && enable)
    ) else $error("index_counter load and enable high together");

endmodule

`default_nettype wire

// File: design/request_fifo.sv
// Synchronous request FIFO
// Circular buffer with occupancy count, programmable-full and a registered read port

`timescale 1ns/1ps
`default_nettype none

`include "csr_index_gen_params.svh"

module request_fifo #(
    parameter int data_w = csr_index_types_pkg::request_w
) (
    input  wire logic                             ap_clk,
    input  wire logic                             areset_generator,
    input  wire logic                             wr_en,
    input  wire logic [data_w-1:0]                din,
    input  wire logic                             rd_en,
    output logic      [data_w-1:0]                dout,
    output logic                                  valid,
    output logic                                  empty,
    output logic                                  full,
    output logic                                  prog_full,
    output csr_index_types_pkg::fifo_level_t      level
);

    localparam int depth = `CSR_FIFO_DEPTH;
    localparam int ptr_w = $clog2(depth);

    logic [data_w-1:0] mem [depth];
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic              wr_ok;
    logic              rd_ok;

    // ----------------------------
    // Status and qualified strobes
    // ----------------------------

    assign empty = (level == '0);
    assign full  = (level == csr_index_types_pkg::fifo_level_t'(depth));

    // Pop only what is there, so the reader may hold rd_en as a level
    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    // ----------------------------
    // Storage
    // ----------------------------

    always_ff @(posedge ap_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
        if (rd_ok) begin
            dout <= mem[rd_ptr];
        end
    end

    // Pointers, occupancy and flags
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            level     <= '0;
            valid     <= 1'b0;
            prog_full <= 1'b0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
            valid <= rd_ok;
            // Follows the level one cycle late
            prog_full <= (level >= csr_index_types_pkg::fifo_level_t'(`CSR_FIFO_PROG_THRESH));
        end
    end

    // ----------------------------
    // Checks
    // ----------------------------

    // The pause threshold must keep the writer off a full FIFO
    a_no_write_when_full : assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        wr_en |-> !full
    ) else $error("request_fifo write while full");

    a_level_in_range : assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        level <= csr_index_types_pkg::fifo_level_t'(depth)
    ) else $error("request_fifo level above depth");

endmodule

`default_nettype wire

// File: design/index_gen_fsm.sv
// Generation sequencer
// Loads the counter, runs it against index_end, pauses on FIFO back-pressure
// and signals the end with a single-cycle done

`timescale 1ns/1ps
`default_nettype none

`include "csr_index_gen_params.svh"

module index_gen_fsm (
    input  wire logic                          ap_clk,
    input  wire logic                          areset_generator,
    input  wire logic                          start,
    input  wire logic                          prog_full,
    input  wire csr_index_types_pkg::index_t   count,
    input  wire csr_index_types_pkg::index_t   index_end,
    output logic                               counter_load,
    output logic                               counter_enable,
    output logic                               push,
    output logic                               done,
    output logic                               busy
);

    csr_index_ctrl_pkg::gen_state_t state;
    csr_index_ctrl_pkg::gen_state_t next_state;

    logic at_end;
    logic step;

    // Count only ever grows, so passing the end also finishes
    assign at_end = (count >= index_end);

    // ----------------------------
    // State register
    // ----------------------------

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= csr_index_ctrl_pkg::GEN_RESET;
        end else begin
            state <= next_state;
        end
    end

    // ----------------------------
    // Next state
    // ----------------------------

    always_comb begin
        next_state = state;
        case (state)
            csr_index_ctrl_pkg::GEN_RESET: begin
                next_state = csr_index_ctrl_pkg::GEN_IDLE;
            end
            csr_index_ctrl_pkg::GEN_IDLE: begin
                if (start) begin
                    next_state = csr_index_ctrl_pkg::GEN_LOAD;
                end
            end
            csr_index_ctrl_pkg::GEN_LOAD: begin
                next_state = csr_index_ctrl_pkg::GEN_START;
            end
            // Lets the loaded count settle before the first compare
            csr_index_ctrl_pkg::GEN_START: begin
                next_state = csr_index_ctrl_pkg::GEN_BUSY;
            end
            csr_index_ctrl_pkg::GEN_BUSY: begin
                if (at_end) begin
                    next_state = csr_index_ctrl_pkg::GEN_DONE;
                end else if (prog_full) begin
                    next_state = csr_index_ctrl_pkg::GEN_PAUSE;
                end
            end
            csr_index_ctrl_pkg::GEN_PAUSE: begin
                if (!prog_full) begin
                    next_state = csr_index_ctrl_pkg::GEN_RESUME;
                end
            end
            csr_index_ctrl_pkg::GEN_RESUME: begin
                next_state = csr_index_ctrl_pkg::GEN_BUSY;
            end
            csr_index_ctrl_pkg::GEN_DONE: begin
                next_state = csr_index_ctrl_pkg::GEN_IDLE;
            end
            default: begin
                next_state = csr_index_ctrl_pkg::GEN_IDLE;
            end
        endcase
    end

    // ----------------------------
    // Outputs
    // ----------------------------

    // One push and one counter step per index, never apart
    assign step = (state == csr_index_ctrl_pkg::GEN_BUSY) && !at_end && !prog_full;

    assign push           = step;
    assign counter_enable = step;
    assign counter_load   = (state == csr_index_ctrl_pkg::GEN_LOAD);
    assign done           = (state == csr_index_ctrl_pkg::GEN_DONE);

    // Low again by the time done pulses
    assign busy = (state == csr_index_ctrl_pkg::GEN_LOAD)  ||
                  (state == csr_index_ctrl_pkg::GEN_START) ||
                  (state == csr_index_ctrl_pkg::GEN_BUSY)  ||
                  (state == csr_index_ctrl_pkg::GEN_PAUSE) ||
                  (state == csr_index_ctrl_pkg::GEN_RESUME);

    // ----------------------------
    // Checks
    // ----------------------------

    a_done_single_cycle : assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        done |=> !done
    ) else $error("index_gen_fsm done held longer than one cycle");

endmodule

`default_nettype wire

// File: design/csr_index_generator.sv
// CSR index generator top level
// Captures the configuration on start, forms shifted-offset requests
// and hands them to the reader through the request FIFO

`timescale 1ns/1ps
`default_nettype none

`include "csr_index_gen_params.svh"

module csr_index_generator (
    input  wire logic                          ap_clk,
    input  wire logic                          areset_generator,
    input  wire logic                          start,
    input  wire csr_index_types_pkg::index_t   index_start,
    input  wire csr_index_types_pkg::index_t   index_end,
    input  wire csr_index_types_pkg::index_t   stride,
    input  wire csr_index_types_pkg::addr_t    array_pointer,
    input  wire csr_index_types_pkg::shift_t   shift_amount,
    input  wire logic                          shift_left,
    input  wire logic                          request_rd_en,
    output logic                               request_valid,
    output csr_index_types_pkg::addr_t         request_base,
    output csr_index_types_pkg::addr_t         request_offset,
    output csr_index_types_pkg::index_t        request_index,
    output logic                               done,
    output logic                               busy
);

    logic start_reg;
    logic start_accept;

    csr_index_types_pkg::index_t index_start_reg;
    csr_index_types_pkg::index_t index_end_reg;
    csr_index_types_pkg::index_t stride_reg;
    csr_index_types_pkg::addr_t  array_pointer_reg;
    csr_index_types_pkg::shift_t shift_amount_reg;
    logic                        shift_left_reg;

    csr_index_types_pkg::index_t count;
    csr_index_types_pkg::addr_t  offset;
    logic                        counter_load;
    logic                        counter_enable;
    logic                        push;
    logic                        prog_full;

    logic [csr_index_types_pkg::request_w-1:0] request_din;
    logic [csr_index_types_pkg::request_w-1:0] request_dout;

    // ----------------------------
    // Configuration capture
    // ----------------------------

    // A start during a generation, or right behind another, is dropped
    assign start_accept = start && !busy && !start_reg;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            start_reg <= 1'b0;
        end else begin
            start_reg <= start_accept;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (start_accept) begin
            index_start_reg   <= index_start;
            index_end_reg     <= index_end;
            stride_reg        <= stride;
            array_pointer_reg <= array_pointer;
            shift_amount_reg  <= shift_amount;
            shift_left_reg    <= shift_left;
        end
    end

    // ----------------------------
    // Request formation
    // ----------------------------

    // Widen the index first so left shifts keep their upper bits
    assign offset = shift_left_reg ?
                    (csr_index_types_pkg::addr_t'(count) << shift_amount_reg) :
                    (csr_index_types_pkg::addr_t'(count) >> shift_amount_reg);

    assign request_din = {array_pointer_reg, offset, count};

    assign {request_base, request_offset, request_index} = request_dout;

    // ----------------------------
    // Submodules
    // ----------------------------

    index_counter u_index_counter (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .load             (counter_load),
        .enable           (counter_enable),
        .load_value       (index_start_reg),
        .stride           (stride_reg),
        .count            (count)
    );

    index_gen_fsm u_index_gen_fsm (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start            (start_reg),
        .prog_full        (prog_full),
        .count            (count),
        .index_end        (index_end_reg),
        .counter_load     (counter_load),
        .counter_enable   (counter_enable),
        .push             (push),
        .done             (done),
        .busy             (busy)
    );

    // The FIFO qualifies rd_en with its own empty flag
    request_fifo #(
        .data_w (csr_index_types_pkg::request_w)
    ) u_request_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .wr_en            (push),
        .din              (request_din),
        .rd_en            (request_rd_en),
        .dout             (request_dout),
        .valid            (request_valid),
        .empty            (),
        .full             (),
        .prog_full        (prog_full),
        .level            ()
    );

endmodule

`default_nettype wire

// File: verification/csr_index_generator_tb.sv
// Testbench for the CSR index generator
// Random generations with reader stalls, a queue-based reference model,
// request, done and busy checks, and a cycle-count timeout

`timescale 1ns/1ps
`default_nettype none

module csr_index_generator_tb;

    localparam int num_gens       = 20;
    localparam int cycles_per_gen = 400;
    localparam int timeout_cycles = num_gens * cycles_per_gen + 1000;

    // Twice the FIFO depth, enough to empty it with rd_en held high
    localparam int drain_limit    = 64;

    logic                        ap_clk;
    logic                        areset_generator;
    logic                        start;
    csr_index_types_pkg::index_t index_start;
    csr_index_types_pkg::index_t index_end;
    csr_index_types_pkg::index_t stride;
    csr_index_types_pkg::addr_t  array_pointer;
    csr_index_types_pkg::shift_t shift_amount;
    logic                        shift_left;
    logic                        request_rd_en;
    logic                        request_valid;
    csr_index_types_pkg::addr_t  request_base;
    csr_index_types_pkg::addr_t  request_offset;
    csr_index_types_pkg::index_t request_index;
    logic                        done;
    logic                        busy;

    // Expected requests, packed as base, offset, index
    logic [csr_index_types_pkg::request_w-1:0] exp_queue[$];

    logic [31:0] rng_state;
    int          stall_left;
    int          cycle_count;
    int          mismatch_errors;
    int          other_errors;
    int          expected_total;
    int          valid_count;
    int          done_count;

    csr_index_generator dut0 (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start            (start),
        .index_start      (index_start),
        .index_end        (index_end),
        .stride           (stride),
        .array_pointer    (array_pointer),
        .shift_amount     (shift_amount),
        .shift_left       (shift_left),
        .request_rd_en    (request_rd_en),
        .request_valid    (request_valid),
        .request_base     (request_base),
        .request_offset   (request_offset),
        .request_index    (request_index),
        .done             (done),
        .busy             (busy)
    );

    initial begin
        ap_clk = 1'b0;
        forever #4 ap_clk = ~ap_clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] t=%0t %s expected 0x%0h actual 0x%0h",
                     $time, name, expected, actual);
            mismatch_errors++;
        end
    endtask

    // Expected requests for one generation, counting up by the stride
    task automatic fill_model(input int unsigned first, input int unsigned last,
                              input int unsigned step, input logic [31:0] base,
                              input logic [4:0] sh, input logic left);
        int unsigned idx;
        logic [31:0] wide;
        logic [31:0] off;
        idx = first;
        while (idx < last) begin
            wide = idx;
            off  = left ? (wide << sh) : (wide >> sh);
            exp_queue.push_back({base, off, idx[15:0]});
            expected_total++;
            idx = idx + step;
        end
    endtask

    // Mostly reading, with an occasional long stall to fill the FIFO
    task automatic drive_read_enable();
        logic [31:0] r;
        r = next_random();
        if (stall_left > 0) begin
            stall_left = stall_left - 1;
            request_rd_en <= 1'b0;
        end else if (r[5:0] == 6'd0) begin
            stall_left = 16 + r[12:8];
            request_rd_en <= 1'b0;
        end else begin
            request_rd_en <= (r[9:8] != 2'b00);
        end
    endtask

    task automatic run_generation(input int gen);
        logic [31:0] r;
        int unsigned first;
        int unsigned last;
        int unsigned step;
        int          done_before;
        int          drain_wait;
        r     = next_random();
        first = r[31:16] % 64;
        last  = r[15:0] % 201;
        step  = 1 + (next_random() % 7);
        // Every fifth generation is empty
        if (gen % 5 == 4) begin
            last = r[15:0] % (first + 1);
        end
        done_before = done_count;
        @(posedge ap_clk);
        index_start   <= first[15:0];
        index_end     <= last[15:0];
        stride        <= step[15:0];
        array_pointer <= next_random();
        shift_amount  <= csr_index_types_pkg::shift_t'(next_random() % 32);
        shift_left    <= gen[0];
        start         <= 1'b1;
        @(posedge ap_clk);
        start <= 1'b0;
        fill_model(first, last, step, array_pointer, shift_amount, shift_left);
        // Reader starts stalled so longer runs hit the pause threshold
        stall_left = 24;
        drive_read_enable();
        while (done_count == done_before) begin
            @(posedge ap_clk);
            drive_read_enable();
        end
        // Drain what is left, then look for stray requests
        stall_left = 0;
        drain_wait = 0;
        request_rd_en <= 1'b1;
        while (exp_queue.size() != 0 && drain_wait < drain_limit) begin
            @(posedge ap_clk);
            drain_wait++;
        end
        request_rd_en <= 1'b0;
        repeat (4) @(posedge ap_clk);
        check_value("done pulses", done_before + 1, done_count);
        check_value("requests left in model", 0, exp_queue.size());
    endtask

    // ------------------------------
    // Output monitor
    // ------------------------------

    always @(negedge ap_clk) begin
        if (!areset_generator) begin
            if (request_valid) begin
                valid_count++;
                if (exp_queue.size() == 0) begin
                    $display("At %0t a request came out while none was expected", $time);
                    other_errors++;
                end else begin
                    check_value("request_base", exp_queue[0][79:48], request_base);
                    check_value("request_offset", exp_queue[0][47:16], request_offset);
                    check_value("request_index", exp_queue[0][15:0], request_index);
                    void'(exp_queue.pop_front());
                end
            end
            if (done) begin
                done_count++;
                check_value("busy", 0, busy);
            end
        end
    end

    always @(posedge ap_clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Run stopped after %0d cycles without finishing", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        rng_state        = 32'd49;
        stall_left       = 0;
        cycle_count      = 0;
        mismatch_errors  = 0;
        other_errors     = 0;
        expected_total   = 0;
        valid_count      = 0;
        done_count       = 0;
        areset_generator = 1'b1;
        start            = 1'b0;
        index_start      = '0;
        index_end        = '0;
        stride           = '0;
        array_pointer    = '0;
        shift_amount     = '0;
        shift_left       = 1'b0;
        request_rd_en    = 1'b0;
        repeat (2) @(posedge ap_clk);
        areset_generator <= 1'b0;
        @(negedge ap_clk);
        check_value("request_valid", 0, request_valid);
        check_value("done", 0, done);
        check_value("busy", 0, busy);
        for (int gen = 0; gen < num_gens; gen++) begin
            run_generation(gen);
        end
        check_value("request count", expected_total, valid_count);
        check_value("model queue size", 0, exp_queue.size());
        check_value("total done pulses", num_gens, done_count);
        $display("Errors: %0d value mismatches, %0d other failures",
                 mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: csr_index_gen.f
+incdir+design
design/csr_index_types_pkg.sv
design/csr_index_ctrl_pkg.sv
design/index_counter.sv
design/request_fifo.sv
design/index_gen_fsm.sv
design/csr_index_generator.sv
verification/csr_index_generator_tb.sv

// File: Makefile
# Verilator build for the CSR index generator testbench
# Override any variable from the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= csr_index_generator_tb
FILELIST  ?= csr_index_gen.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_TEXT ?= TEST PASSED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard design/*.sv design/*.svh verification/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the log holds the pass line
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
